//--- design/decode_pkg.sv
// Shared definitions for the operand-decode stage
// Opcodes, postfix field positions, register numbers and the bundle and micro-op types

package decode_pkg;

	// ========================================================================
	// Opcodes and register numbers
	// ========================================================================

	// Architectural register number, 127 is hardwired zero and 0 means no operand
	typedef logic [6:0] aregno_t;

	localparam aregno_t AREG_NONE = 7'd0;
	localparam aregno_t AREG_ZERO = 7'd127;

	// Primary opcodes seen in the low word of a bundle
	typedef enum logic [6:0] {
		OP_ADD   = 7'h04,
		OP_SUB   = 7'h05,
		OP_AND   = 7'h08,
		OP_R3B   = 7'h10,
		OP_R3W   = 7'h11,
		OP_R3T   = 7'h12,
		OP_R3O   = 7'h13,
		OP_BEQ   = 7'h26,
		OP_BNE   = 7'h27,
		OP_STB   = 7'h38,
		OP_STW   = 7'h39,
		OP_STT   = 7'h3a,
		OP_STORE = 7'h3b,
		OP_STI   = 7'h3c,
		OP_STPTR = 7'h3d
	} opcode_t;

	// Postfix opcodes, they live in the low 7 bits of the postfix slot
	localparam logic [6:0] OP_REXT = 7'h7d;
	localparam logic [6:0] OP_IMMC = 7'h7e;

	// ========================================================================
	// Field positions within the 96-bit bundle
	// ========================================================================

	localparam int POSTFIX_OP_LSB = 48;
	localparam int REXT_RD_LSB    = 55;
	localparam int REXT_RS1_LSB   = 62;
	localparam int REXT_RS2_LSB   = 69;
	localparam int REXT_RS3_LSB   = 76;
	localparam int IMMC_LSB       = 55;

	// The 48-bit instruction word, most significant member first
	typedef struct packed {
		logic [15:0] imm16;
		logic [4:0]  rsv;
		logic [4:0]  rs3;
		logic [4:0]  rs2;
		logic [4:0]  rs1;
		logic [4:0]  rd;
		opcode_t     opcode;
	} instr_word_t;

	// Word in the low half and one postfix slot in the high half
	typedef struct packed {
		logic [47:0] postfix;
		instr_word_t word;
	} fetch_bundle_t;

	// Decoded micro-op handed to the rename stage, 73 bits
	typedef struct packed {
		opcode_t     opcode;
		aregno_t     rd;
		aregno_t     rs1;
		aregno_t     rs2;
		aregno_t     rs3;
		logic        rdz;
		logic        rs1z;
		logic        rs2z;
		logic        rs3z;
		logic        has_immc;
		logic        has_rext;
		logic [31:0] imm;
	} decoded_op_t;

	// ========================================================================
	// Opcode classes
	// ========================================================================

	function automatic logic is_store(opcode_t op);
		return op inside {OP_STB, OP_STW, OP_STT, OP_STORE, OP_STI, OP_STPTR};
	endfunction

	function automatic logic is_r3(opcode_t op);
		return op inside {OP_R3B, OP_R3W, OP_R3T, OP_R3O};
	endfunction

	function automatic logic is_branch(opcode_t op);
		return op inside {OP_BEQ, OP_BNE};
	endfunction

endpackage

//--- design/hs_slot.sv
// Handshake slot
// One-entry holding register between a four-phase req/ack sink and source

`timescale 1ns/1ps

module hs_slot #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     snk_req,
	output logic     snk_ack,
	input  payload_t snk_data,
	output logic     src_req,
	input  logic     src_ack,
	output payload_t src_data
);

	logic     full;
	logic     capture;
	payload_t data_q;

	// Take a new item only when empty, the sink cycle has returned to zero
	// and the downstream ack from the previous item has dropped
	assign capture = snk_req && !full && !snk_ack && !src_ack;

	// ========================================================================
	// Control state
	// ========================================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			full    <= 1'b0;
			snk_ack <= 1'b0;
		end
		else
		begin
			// Sink side, ack rises on capture and falls once req is seen low
			if (capture)
				snk_ack <= 1'b1;
			else if (snk_ack && !snk_req)
				snk_ack <= 1'b0;

			// Source side, the entry stays full until the consumer acks it
			if (capture)
				full <= 1'b1;
			else if (full && src_ack)
				full <= 1'b0;
		end
	end

	// Payload register, written only at capture
	always_ff @(posedge clk)
	begin
		if (capture)
			data_q <= snk_data;
	end

	// The outgoing request is the full flag itself
	assign src_req  = full;
	assign src_data = data_q;

	// ========================================================================
	// Assertions
	// ========================================================================

	// Payload holds steady for as long as the request waits for its ack
	a_src_stable: assert property (@(posedge clk) disable iff (!arst_n)
		src_req && !src_ack |=> $stable(src_data));

	// A sink ack only rises out of an empty slot, so nothing is overwritten
	a_no_capture_full: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(snk_ack) |-> $past(!full));

endmodule

//--- design/decode_imm.sv
// Postfix and immediate decoder
// Spots IMMC and REXT postfixes and forms the 32-bit immediate

`timescale 1ns/1ps

module decode_imm (
	input  decode_pkg::fetch_bundle_t bundle,
	output logic                      has_immc,
	output logic                      has_rext,
	output logic [31:0]               imm
);

	logic [6:0]  post_op;
	logic [31:0] immc_val;
	logic [31:0] imm16_sx;

	// ========================================================================
	// Postfix detection
	// ========================================================================

	// Only one postfix slot exists, so at most one of the flags is set
	assign post_op = bundle[decode_pkg::POSTFIX_OP_LSB +: 7];

	assign has_immc = (post_op == decode_pkg::OP_IMMC);
	assign has_rext = (post_op == decode_pkg::OP_REXT);

	// ========================================================================
	// Immediate
	// ========================================================================

	// The constant carried by an IMMC postfix sits just above its opcode
	assign immc_val = bundle[decode_pkg::IMMC_LSB +: 32];

	// Word immediate, sign-extended from bit 15
	assign imm16_sx = {{16{bundle.word.imm16[15]}}, bundle.word.imm16};

	// An IMMC constant takes priority over the short word immediate
	always_comb
	begin
		if (has_immc)
			imm = immc_val;
		else
			imm = imm16_sx;
	end

endmodule

//--- design/decode_reg_fields.sv
// Register field decoder
// Forms Rd, Rs1 and Rs2 from the word or a REXT postfix, with zero-register flags

`timescale 1ns/1ps

module decode_reg_fields (
	input  decode_pkg::fetch_bundle_t bundle,
	input  logic                      has_rext,
	output decode_pkg::aregno_t       rd,
	output decode_pkg::aregno_t       rs1,
	output decode_pkg::aregno_t       rs2,
	output logic                      rdz,
	output logic                      rs1z,
	output logic                      rs2z
);

	decode_pkg::aregno_t rd_raw;
	logic                no_dest;

	// ========================================================================
	// Field selection
	// ========================================================================

	// A REXT postfix carries full 7-bit numbers and supersedes the 5-bit fields
	always_comb
	begin
		if (has_rext)
		begin
			rd_raw = bundle[decode_pkg::REXT_RD_LSB +: 7];
			rs1    = bundle[decode_pkg::REXT_RS1_LSB +: 7];
			rs2    = bundle[decode_pkg::REXT_RS2_LSB +: 7];
		end
		else
		begin
			// Plain words reach only the low 32 registers
			rd_raw = {2'b00, bundle.word.rd};
			rs1    = {2'b00, bundle.word.rs1};
			rs2    = {2'b00, bundle.word.rs2};
		end
	end

	// ========================================================================
	// Destination
	// ========================================================================

	// Stores use the Rd field for their data and branches write nothing
	assign no_dest = decode_pkg::is_store(bundle.word.opcode) ||
		decode_pkg::is_branch(bundle.word.opcode);

	assign rd = no_dest ? decode_pkg::AREG_NONE : rd_raw;

	// Zero flags mark the hardwired-zero register
	assign rdz  = (rd == decode_pkg::AREG_ZERO);
	assign rs1z = (rs1 == decode_pkg::AREG_ZERO);
	assign rs2z = (rs2 == decode_pkg::AREG_ZERO);

endmodule

//--- design/decode_rs3.sv
// Third source register decoder
// Picks Rs3 by opcode class, REXT postfix and IMMC constant override

`timescale 1ns/1ps

module decode_rs3 (
	input  decode_pkg::fetch_bundle_t bundle,
	input  logic                      has_immc,
	input  logic                      has_rext,
	output decode_pkg::aregno_t       rs3,
	output logic                      rs3z
);

	decode_pkg::aregno_t rext_rs3;
	decode_pkg::opcode_t op;

	assign op       = bundle.word.opcode;
	assign rext_rs3 = bundle[decode_pkg::REXT_RS3_LSB +: 7];

	// An IMMC constant takes the place of the third operand
	always_comb
	begin
		if (has_immc)
			rs3 = decode_pkg::AREG_NONE;
		else if (decode_pkg::is_store(op))
		begin
			// Store data is named by the word's Rd field
			rs3 = has_rext ? rext_rs3 : {2'b00, bundle.word.rd};
		end
		else if (decode_pkg::is_r3(op))
			rs3 = has_rext ? rext_rs3 : {2'b00, bundle.word.rs3};
		else
			rs3 = decode_pkg::AREG_NONE;
	end

	assign rs3z = (rs3 == decode_pkg::AREG_ZERO);

endmodule

//--- design/decode_top.sv
// Operand-decode stage top level
// Input slot, combinational decoders and an output slot on four-phase links

`timescale 1ns/1ps

module decode_top (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      in_req,
	output logic                      in_ack,
	input  decode_pkg::fetch_bundle_t in_bundle,
	output logic                      out_req,
	input  logic                      out_ack,
	output decode_pkg::decoded_op_t   out_op
);

	decode_pkg::fetch_bundle_t held;
	decode_pkg::decoded_op_t   mid_op;
	logic                      mid_req;
	logic                      mid_ack;

	// ========================================================================
	// Input slot, the decoders read its held bundle
	// ========================================================================

	hs_slot #(.payload_t(decode_pkg::fetch_bundle_t)) slot_in (
		.clk(clk), .arst_n(arst_n),
		.snk_req(in_req), .snk_ack(in_ack), .snk_data(in_bundle),
		.src_req(mid_req), .src_ack(mid_ack), .src_data(held)
	);

	// Postfix flags feed both register decoders
	decode_imm u_imm (
		.bundle(held), .has_immc(mid_op.has_immc), .has_rext(mid_op.has_rext),
		.imm(mid_op.imm)
	);

	decode_reg_fields u_regs (
		.bundle(held), .has_rext(mid_op.has_rext),
		.rd(mid_op.rd), .rs1(mid_op.rs1), .rs2(mid_op.rs2),
		.rdz(mid_op.rdz), .rs1z(mid_op.rs1z), .rs2z(mid_op.rs2z)
	);

	decode_rs3 u_rs3 (
		.bundle(held), .has_immc(mid_op.has_immc), .has_rext(mid_op.has_rext),
		.rs3(mid_op.rs3), .rs3z(mid_op.rs3z)
	);

	assign mid_op.opcode = held.word.opcode;

	// ========================================================================
	// Output slot
	// ========================================================================

	hs_slot #(.payload_t(decode_pkg::decoded_op_t)) slot_out (
		.clk(clk), .arst_n(arst_n),
		.snk_req(mid_req), .snk_ack(mid_ack), .snk_data(mid_op),
		.src_req(out_req), .src_ack(out_ack), .src_data(out_op)
	);

endmodule

//--- tb/decode_tb.sv
// Testbench for the operand-decode stage
// Four-phase driver and responder, a reference decode model and
// concurrent assertions on both links and on every decoded micro-op

`timescale 1ns/1ps

module decode_tb;

	localparam int ACK_LIMIT   = 200;
	localparam int HOLD_LIMIT  = 300;
	localparam int DRAIN_LIMIT = 500;
	localparam int KIND_PLAIN  = 0;
	localparam int KIND_REXT   = 1;
	localparam int KIND_IMMC   = 2;

	// Hardwired-zero register number
	localparam logic [6:0] ZERO_REG = 7'd127;

	logic                      clk;
	logic                      arst_n;
	logic                      in_req;
	logic                      in_ack;
	decode_pkg::fetch_bundle_t in_bundle;
	logic                      out_req;
	logic                      out_ack;
	decode_pkg::decoded_op_t   out_op;

	// Scoreboard state, the queues hold items sent but not yet seen at the output
	decode_pkg::fetch_bundle_t sent_q[$];
	int                        cyc_q[$];
	decode_pkg::decoded_op_t   exp_head;
	int                        head_cyc;
	int                        cyc;
	int                        in_cnt;
	int                        out_cnt;
	int                        errors;
	logic                      out_prev;
	logic                      hold_bp;

	decode_pkg::opcode_t op_table[15] = '{
		decode_pkg::OP_ADD, decode_pkg::OP_SUB, decode_pkg::OP_AND, decode_pkg::OP_R3B,
		decode_pkg::OP_R3W, decode_pkg::OP_R3T, decode_pkg::OP_R3O, decode_pkg::OP_STB,
		decode_pkg::OP_STW, decode_pkg::OP_STT, decode_pkg::OP_STORE, decode_pkg::OP_STI,
		decode_pkg::OP_STPTR, decode_pkg::OP_BEQ, decode_pkg::OP_BNE};

	decode_top dut0 (
		.clk(clk), .arst_n(arst_n),
		.in_req(in_req), .in_ack(in_ack), .in_bundle(in_bundle),
		.out_req(out_req), .out_ack(out_ack), .out_op(out_op)
	);

	always #4 clk = ~clk;

	// ========================================================================
	// Reference model and stimulus helpers
	// ========================================================================

	function automatic decode_pkg::decoded_op_t expected_op(input decode_pkg::fetch_bundle_t b);
		decode_pkg::decoded_op_t e;
		logic [6:0]              post_op;
		logic                    store_op;
		logic                    r3_op;
		logic                    branch_op;
		post_op   = b[decode_pkg::POSTFIX_OP_LSB +: 7];
		store_op  = 1'b0;
		r3_op     = 1'b0;
		branch_op = 1'b0;
		case (b.word.opcode)
			decode_pkg::OP_STB, decode_pkg::OP_STW, decode_pkg::OP_STT,
			decode_pkg::OP_STORE, decode_pkg::OP_STI, decode_pkg::OP_STPTR:
				store_op = 1'b1;
			decode_pkg::OP_R3B, decode_pkg::OP_R3W, decode_pkg::OP_R3T, decode_pkg::OP_R3O:
				r3_op = 1'b1;
			decode_pkg::OP_BEQ, decode_pkg::OP_BNE:
				branch_op = 1'b1;
			default: ;
		endcase
		e          = '0;
		e.opcode   = b.word.opcode;
		e.has_immc = (post_op == decode_pkg::OP_IMMC);
		e.has_rext = (post_op == decode_pkg::OP_REXT);
		if (e.has_rext)
		begin
			e.rd  = b[decode_pkg::REXT_RD_LSB +: 7];
			e.rs1 = b[decode_pkg::REXT_RS1_LSB +: 7];
			e.rs2 = b[decode_pkg::REXT_RS2_LSB +: 7];
		end
		else
		begin
			e.rd  = {2'b00, b.word.rd};
			e.rs1 = {2'b00, b.word.rs1};
			e.rs2 = {2'b00, b.word.rs2};
		end
		// No destination for stores and branches
		if (store_op || branch_op)
			e.rd = 7'd0;
		if (e.has_immc)
			e.rs3 = 7'd0;
		else if (store_op)
			e.rs3 = e.has_rext ? b[decode_pkg::REXT_RS3_LSB +: 7] : {2'b00, b.word.rd};
		else if (r3_op)
			e.rs3 = e.has_rext ? b[decode_pkg::REXT_RS3_LSB +: 7] : {2'b00, b.word.rs3};
		e.rdz  = (e.rd == ZERO_REG);
		e.rs1z = (e.rs1 == ZERO_REG);
		e.rs2z = (e.rs2 == ZERO_REG);
		e.rs3z = (e.rs3 == ZERO_REG);
		e.imm  = e.has_immc ? b[decode_pkg::IMMC_LSB +: 32] :
			{{16{b.word.imm16[15]}}, b.word.imm16};
		return e;
	endfunction

	// About one register in four is the zero register
	function automatic logic [6:0] pick_reg();
		if ($urandom_range(3, 0) == 0)
			return ZERO_REG;
		return 7'($urandom);
	endfunction

	function automatic decode_pkg::fetch_bundle_t make_bundle(input decode_pkg::opcode_t op,
		input int kind);
		decode_pkg::fetch_bundle_t b;
		b = {$urandom, $urandom, $urandom};
		b.word.opcode = op;
		if (kind == KIND_REXT)
		begin
			b[decode_pkg::POSTFIX_OP_LSB +: 7] = decode_pkg::OP_REXT;
			b[decode_pkg::REXT_RD_LSB +: 7]    = pick_reg();
			b[decode_pkg::REXT_RS1_LSB +: 7]   = pick_reg();
			b[decode_pkg::REXT_RS2_LSB +: 7]   = pick_reg();
			b[decode_pkg::REXT_RS3_LSB +: 7]   = pick_reg();
		end
		else if (kind == KIND_IMMC)
			b[decode_pkg::POSTFIX_OP_LSB +: 7] = decode_pkg::OP_IMMC;
		else
			b[decode_pkg::POSTFIX_OP_LSB +: 7] = 7'h00;
		return b;
	endfunction

	task automatic abort_run(input string why);
		$display("Run stopped: %s", why);
		$display("RESULT: FAIL");
		$finish;
	endtask

	// Full four-phase send, entered and left 1 ns after a rising edge
	task automatic send_bundle(input decode_pkg::fetch_bundle_t b);
		int t;
		sent_q.push_back(b);
		cyc_q.push_back(cyc);
		in_bundle = b;
		in_req    = 1'b1;
		in_cnt++;
		t = 0;
		do
		begin
			@(posedge clk);
			#1;
			t++;
			if (t > ACK_LIMIT)
				abort_run("in_ack never rose for a pending request");
		end
		while (!in_ack);
		in_req = 1'b0;
		t = 0;
		do
		begin
			@(posedge clk);
			#1;
			t++;
			if (t > ACK_LIMIT)
				abort_run("in_ack never fell after the request dropped");
		end
		while (in_ack);
	endtask

	// Waits until every sent item has come out and both links are quiet
	task automatic wait_idle();
		int t;
		t = 0;
		while (out_cnt < in_cnt || out_req || out_ack || in_ack)
		begin
			@(posedge clk);
			#1;
			t++;
			if (t > DRAIN_LIMIT)
				abort_run("the stage did not drain all sent items");
		end
	endtask

	task automatic report_test(input string name, input int in_mark, input int err_mark);
		$display("test %s: %0d items, %0d errors", name, in_cnt - in_mark, errors - err_mark);
	endtask

	// ========================================================================
	// Output monitor and responder
	// ========================================================================

	// Retires the queue head at each out_req rise and presents the next expectation
	always @(posedge clk)
	begin : track_output
		if (!arst_n)
			out_prev = 1'b0;
		else
		begin
			if (out_req && !out_prev)
			begin
				if (sent_q.size() == 0)
				begin
					$display("Output item appeared with no item sent");
					errors++;
				end
				else
				begin
					void'(sent_q.pop_front());
					void'(cyc_q.pop_front());
				end
				out_cnt++;
			end
			out_prev = out_req;
			if (sent_q.size() != 0)
			begin
				exp_head = expected_op(sent_q[0]);
				head_cyc = cyc_q[0];
			end
		end
		cyc = cyc + 1;
	end

	// Acknowledges each output after 0 to 5 cycles, or later under held back-pressure
	always
	begin : respond
		int unsigned delay;
		int          t;
		@(posedge clk);
		if (arst_n && out_req && !out_ack)
		begin
			delay = $urandom_range(5, 0);
			repeat (delay) @(posedge clk);
			t = 0;
			while (hold_bp)
			begin
				@(posedge clk);
				t++;
				if (t > HOLD_LIMIT)
					abort_run("back-pressure was never released");
			end
			#1;
			out_ack = 1'b1;
			t = 0;
			do
			begin
				@(posedge clk);
				t++;
				if (t > ACK_LIMIT)
					abort_run("out_req stayed high after out_ack");
			end
			while (out_req);
			#1;
			out_ack = 1'b0;
		end
	end

	// ========================================================================
	// Assertions
	// ========================================================================

	// Once reset has been held for a full cycle both links stay quiet
	a_reset_quiet: assert property (@(posedge clk)
		!arst_n && $past(!arst_n) |-> !in_ack && !out_req)
		else begin $display("in_ack or out_req high during reset"); errors++; end

	a_in_ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(in_ack) |-> $past(in_req))
		else begin $display("in_ack rose without a request"); errors++; end

	a_in_ack_hold: assert property (@(posedge clk) disable iff (!arst_n)
		in_ack && in_req |=> in_ack)
		else begin $display("in_ack dropped while in_req was still high"); errors++; end

	a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
		out_req && !out_ack |=> out_req && $stable(out_op))
		else begin $display("out_req or out_op changed before out_ack"); errors++; end

	a_out_rtz: assert property (@(posedge clk) disable iff (!arst_n)
		out_ack && !out_req |=> !out_req)
		else begin $display("out_req rose again before out_ack fell"); errors++; end

	a_out_op: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(out_req) |-> out_op == exp_head)
		else
		begin
			$display("CHECK FAILED out_op got %h expected %h",
				$sampled(out_op), $sampled(exp_head));
			errors++;
		end

	// Two edges at least between the request being driven and out_req seen high
	a_latency: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(out_req) |-> cyc - head_cyc >= 2)
		else begin $display("out_req rose too soon after its request"); errors++; end

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial
	begin : main
		int in_mark;
		int err_mark;
		int i;
		void'($urandom(32'hc13a));
		clk       = 1'b0;
		arst_n    = 1'b0;
		in_req    = 1'b0;
		in_bundle = '0;
		out_ack   = 1'b0;
		hold_bp   = 1'b0;
		cyc       = 0;
		in_cnt    = 0;
		out_cnt   = 0;
		errors    = 0;
		head_cyc  = 0;
		exp_head  = '0;
		repeat (4) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// Test 1, idle after reset then a few items through both links
		in_mark  = in_cnt;
		err_mark = errors;
		assert (!in_ack && !out_req)
			else begin $display("in_ack or out_req high after reset"); errors++; end
		for (i = 0; i < 4; i++)
			send_bundle(make_bundle(op_table[i], KIND_PLAIN));
		wait_idle();
		report_test("reset and handshake", in_mark, err_mark);

		// Test 2, plain words over every opcode
		in_mark  = in_cnt;
		err_mark = errors;
		for (i = 0; i < 60; i++)
			send_bundle(make_bundle(op_table[i % 15], KIND_PLAIN));
		wait_idle();
		report_test("plain words", in_mark, err_mark);

		// Test 3, register extension with frequent zero registers
		in_mark  = in_cnt;
		err_mark = errors;
		for (i = 0; i < 45; i++)
			send_bundle(make_bundle(op_table[i % 15], KIND_REXT));
		wait_idle();
		report_test("register extension", in_mark, err_mark);

		// Test 4, immediate constants, stores and R3 ops included
		in_mark  = in_cnt;
		err_mark = errors;
		for (i = 0; i < 45; i++)
			send_bundle(make_bundle(op_table[i % 15], KIND_IMMC));
		wait_idle();
		report_test("immediate constant", in_mark, err_mark);

		// Test 5, back-to-back random stream with bursts of held back-pressure
		in_mark  = in_cnt;
		err_mark = errors;
		fork
			begin
				for (i = 0; i < 200; i++)
					send_bundle(make_bundle(op_table[$urandom_range(14, 0)],
						$urandom_range(2, 0)));
			end
			begin
				repeat (6)
				begin
					repeat ($urandom_range(60, 20)) @(posedge clk);
					#1 hold_bp = 1'b1;
					repeat ($urandom_range(40, 10)) @(posedge clk);
					#1 hold_bp = 1'b0;
				end
			end
		join
		wait_idle();
		assert (out_cnt == in_cnt && sent_q.size() == 0)
			else begin $display("items out do not match items in"); errors++; end
		report_test("random stream", in_mark, err_mark);

		$display("items in %0d, items out %0d, errors %0d", in_cnt, out_cnt, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- sim.f
design/decode_pkg.sv
design/hs_slot.sv
design/decode_imm.sv
design/decode_reg_fields.sv
design/decode_rs3.sv
design/decode_top.sv
tb/decode_tb.sv
